// ==== hw/tlb_pkg.sv ====
package tlb_pkg;

    localparam int TLB_INDEX_W     = 4;
    localparam int TLB_ENTRIES_MAX = 16;

    typedef logic [18:0]            vpn2_t;       // va[31:13], one even/odd page pair
    typedef logic [7:0]             asid_t;
    typedef logic [19:0]            pfn_t;
    typedef logic [2:0]             cache_attr_t;
    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;

    // one page half of an entry
    typedef struct packed {
        pfn_t        pfn;
        cache_attr_t c;
        logic        d;
        logic        v;
    } tlb_lo_t;

    typedef struct packed {
        vpn2_t   vpn2;
        asid_t   asid;
        logic    g;                               // global, asid ignored
        tlb_lo_t lo0;                             // even page
        tlb_lo_t lo1;                             // odd page
    } tlb_entry_t;

    typedef struct packed {
        vpn2_t vpn2;
        logic  odd_page;                          // va[12]
        asid_t asid;
    } lookup_req_t;

    typedef struct packed {
        logic       found;
        tlb_index_t index;
        tlb_lo_t    lo;
    } lookup_rsp_t;

    typedef enum logic [1:0] {
        op_write_index,
        op_write_random,
        op_probe
    } tlb_op_e;

    // probe looks only at entry.vpn2 and entry.asid
    typedef struct packed {
        tlb_op_e    op;
        tlb_index_t index;
        tlb_entry_t entry;
    } tlb_cmd_t;

    typedef struct packed {
        tlb_op_e    op;
        logic       found;
        tlb_index_t index;
    } tlb_cmd_rsp_t;

endpackage

// ==== hw/tlb_entry_array.sv ====
`timescale 1ns/1ps

module tlb_entry_array #(
    parameter int tlb_entries = 16
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  tlb_pkg::tlb_index_t    wr_index,
    input  tlb_pkg::tlb_entry_t    wr_entry,
    output tlb_pkg::tlb_entry_t    entries [tlb_entries],
    output logic [tlb_entries-1:0] present
);

    // entry payload, only meaningful where present is set
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            present <= '0;
        end else if (wr_en) begin
            present[wr_index] <= 1'b1;   // never cleared except by reset
        end
    end

    // both the indexed and the random write path must stay inside the array
    a_wr_index_range: assert property (
        @(posedge aclk) disable iff (reset)
        wr_en |-> (wr_index < tlb_entries)
    );

endmodule

// ==== hw/tlb_match.sv ====
`timescale 1ns/1ps

module tlb_match #(
    parameter int tlb_entries = 16
) (
    input  tlb_pkg::tlb_entry_t    entries [tlb_entries],
    input  logic [tlb_entries-1:0] present,
    input  tlb_pkg::lookup_req_t   req,
    output tlb_pkg::lookup_rsp_t   rsp
);

    import tlb_pkg::*;

    logic [tlb_entries-1:0] hit;
    tlb_index_t             hit_index;
    tlb_lo_t                hit_lo;

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit[i] = present[i]
                  && (entries[i].vpn2 == req.vpn2)
                  && (entries[i].g || (entries[i].asid == req.asid));
        end
    end

    // scan from the top so the lowest hit is the last one kept
    always_comb begin
        hit_index = '0;
        hit_lo    = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_index = tlb_index_t'(i);
                hit_lo    = req.odd_page ? entries[i].lo1 : entries[i].lo0;
            end
        end
    end

    always_comb begin
        rsp       = '0;   // miss reports all zero
        rsp.found = |hit;
        if (|hit) begin
            rsp.index = hit_index;
            rsp.lo    = hit_lo;
        end
    end

endmodule

// ==== hw/tlb_lookup_port.sv ====
`timescale 1ns/1ps

module tlb_lookup_port #(
    parameter int tlb_entries = 16
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  tlb_pkg::tlb_entry_t    entries [tlb_entries],
    input  logic [tlb_entries-1:0] present,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  tlb_pkg::lookup_req_t   req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output tlb_pkg::lookup_rsp_t   rsp
);

    import tlb_pkg::*;

    lookup_rsp_t match_rsp;
    logic        req_fire;

    tlb_match #(
        .tlb_entries (tlb_entries)
    ) i_match (
        .entries (entries),
        .present (present),
        .req     (req),
        .rsp     (match_rsp)
    );

    // one deep buffer, refill allowed while draining
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_fire) begin
            rsp <= match_rsp;   // array state before this edge's write
        end
    end

    a_rsp_hold: assert property (
        @(posedge aclk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    );

    a_rsp_reset: assert property (
        @(posedge aclk) reset |=> !rsp_valid
    );

endmodule

// ==== hw/tlb_cmd_unit.sv ====
`timescale 1ns/1ps

module tlb_cmd_unit #(
    parameter int tlb_entries = 16
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  tlb_pkg::tlb_entry_t    entries [tlb_entries],
    input  logic [tlb_entries-1:0] present,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  tlb_pkg::tlb_cmd_t      cmd,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output tlb_pkg::tlb_cmd_rsp_t  rsp,
    output logic                   wr_en,
    output tlb_pkg::tlb_index_t    wr_index,
    output tlb_pkg::tlb_entry_t    wr_entry
);

    import tlb_pkg::*;

    localparam tlb_index_t last_index = tlb_index_t'(tlb_entries - 1);

    tlb_index_t  random_index;
    lookup_req_t probe_req;
    lookup_rsp_t probe_rsp;
    logic        cmd_fire;
    logic        is_probe;

    // probe ignores the page half, only found and index are kept
    always_comb begin
        probe_req          = '0;
        probe_req.vpn2     = cmd.entry.vpn2;
        probe_req.asid     = cmd.entry.asid;
        probe_req.odd_page = 1'b0;
    end

    tlb_match #(
        .tlb_entries (tlb_entries)
    ) i_probe_match (
        .entries (entries),
        .present (present),
        .req     (probe_req),
        .rsp     (probe_rsp)
    );

    assign cmd_ready = !rsp_valid || rsp_ready;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign is_probe  = (cmd.op == op_probe);

    // array takes the write on the accepting edge
    assign wr_en    = cmd_fire && !is_probe;
    assign wr_index = (cmd.op == op_write_random) ? random_index : cmd.index;
    assign wr_entry = cmd.entry;

    // steps only on random writes so the sequence is repeatable
    always_ff @(posedge aclk) begin
        if (reset) begin
            random_index <= last_index;
        end else if (cmd_fire && (cmd.op == op_write_random)) begin
            if (random_index == '0) begin
                random_index <= last_index;
            end else begin
                random_index <= random_index - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (cmd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_fire) begin
            rsp.op    <= cmd.op;
            rsp.found <= is_probe && probe_rsp.found;   // low for writes
            rsp.index <= is_probe ? probe_rsp.index : wr_index;
        end
    end

    a_write_index_range: assert property (
        @(posedge aclk) disable iff (reset)
        (cmd_fire && (cmd.op == op_write_index)) |-> (cmd.index < tlb_entries)
    );

endmodule

// ==== hw/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top #(
    parameter int tlb_entries = tlb_pkg::TLB_ENTRIES_MAX
) (
    input  logic                  aclk,
    input  logic                  reset,
    // instruction side, driven with the fetch pc
    input  logic                  ifetch_req_valid,
    output logic                  ifetch_req_ready,
    input  tlb_pkg::lookup_req_t  ifetch_req,
    output logic                  ifetch_rsp_valid,
    input  logic                  ifetch_rsp_ready,
    output tlb_pkg::lookup_rsp_t  ifetch_rsp,
    // data side, driven with the load/store address
    input  logic                  data_req_valid,
    output logic                  data_req_ready,
    input  tlb_pkg::lookup_req_t  data_req,
    output logic                  data_rsp_valid,
    input  logic                  data_rsp_ready,
    output tlb_pkg::lookup_rsp_t  data_rsp,
    // cp0 tlbwi / tlbwr / tlbp
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  tlb_pkg::tlb_cmd_t     cmd,
    output logic                  cmd_rsp_valid,
    input  logic                  cmd_rsp_ready,
    output tlb_pkg::tlb_cmd_rsp_t cmd_rsp
);

    import tlb_pkg::*;

    tlb_entry_t             entries [tlb_entries];
    logic [tlb_entries-1:0] present;
    logic                   wr_en;
    tlb_index_t             wr_index;
    tlb_entry_t             wr_entry;

    tlb_entry_array #(
        .tlb_entries (tlb_entries)
    ) i_entry_array (
        .aclk     (aclk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .entries  (entries),
        .present  (present)
    );

    tlb_lookup_port #(
        .tlb_entries (tlb_entries)
    ) i_ifetch_port (
        .aclk      (aclk),
        .reset     (reset),
        .entries   (entries),
        .present   (present),
        .req_valid (ifetch_req_valid),
        .req_ready (ifetch_req_ready),
        .req       (ifetch_req),
        .rsp_valid (ifetch_rsp_valid),
        .rsp_ready (ifetch_rsp_ready),
        .rsp       (ifetch_rsp)
    );

    tlb_lookup_port #(
        .tlb_entries (tlb_entries)
    ) i_data_port (
        .aclk      (aclk),
        .reset     (reset),
        .entries   (entries),
        .present   (present),
        .req_valid (data_req_valid),
        .req_ready (data_req_ready),
        .req       (data_req),
        .rsp_valid (data_rsp_valid),
        .rsp_ready (data_rsp_ready),
        .rsp       (data_rsp)
    );

    tlb_cmd_unit #(
        .tlb_entries (tlb_entries)
    ) i_cmd_unit (
        .aclk      (aclk),
        .reset     (reset),
        .entries   (entries),
        .present   (present),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (cmd_rsp_valid),
        .rsp_ready (cmd_rsp_ready),
        .rsp       (cmd_rsp),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_entry  (wr_entry)
    );

endmodule

// ==== dv/tlb_tb.sv ====
`timescale 1ns/1ps

module tlb_tb;

    import tlb_pkg::*;

    localparam int n_entries       = 12;   // not a power of two so the random wrap shows
    localparam int n_cmds          = 300;
    localparam int n_lookups       = 300;  // per lookup port
    localparam int num_ops         = n_cmds + 2 * n_lookups;
    localparam int reset_cycles    = 16;
    localparam int watchdog_cycles = reset_cycles + num_ops * 20;

    logic         aclk;
    logic         reset = 1'b1;
    logic         ifetch_req_valid = 1'b0;
    logic         ifetch_req_ready;
    lookup_req_t  ifetch_req = '0;
    logic         ifetch_rsp_valid;
    logic         ifetch_rsp_ready = 1'b0;
    lookup_rsp_t  ifetch_rsp;
    logic         data_req_valid = 1'b0;
    logic         data_req_ready;
    lookup_req_t  data_req = '0;
    logic         data_rsp_valid;
    logic         data_rsp_ready = 1'b0;
    lookup_rsp_t  data_rsp;
    logic         cmd_valid = 1'b0;
    logic         cmd_ready;
    tlb_cmd_t     cmd = '0;
    logic         cmd_rsp_valid;
    logic         cmd_rsp_ready = 1'b0;
    tlb_cmd_rsp_t cmd_rsp;

    // reference model
    tlb_entry_t           ref_entries [n_entries];
    logic [n_entries-1:0] ref_present = '0;
    tlb_index_t           ref_random  = tlb_index_t'(n_entries - 1);

    lookup_rsp_t  exp_ifetch [$];
    lookup_rsp_t  exp_data [$];
    tlb_cmd_rsp_t exp_cmd [$];

    int           ifetch_issued = 0;
    int           data_issued   = 0;
    int           cmd_issued    = 0;
    logic         ifetch_hold   = 1'b0;
    logic         data_hold     = 1'b0;
    logic         cmd_hold      = 1'b0;
    lookup_rsp_t  ifetch_held;
    lookup_rsp_t  data_held;
    tlb_cmd_rsp_t cmd_held;
    integer       seed = 32'h69f3;

    // small pools so that hits and duplicate entries are common
    vpn2_t vpn2_pool [4] = '{19'h00012, 19'h7ff01, 19'h12345, 19'h00000};
    asid_t asid_pool [3] = '{8'h01, 8'h5a, 8'hff};

    tlb_top #(
        .tlb_entries (n_entries)
    ) i_dut (
        .aclk             (aclk),
        .reset            (reset),
        .ifetch_req_valid (ifetch_req_valid),
        .ifetch_req_ready (ifetch_req_ready),
        .ifetch_req       (ifetch_req),
        .ifetch_rsp_valid (ifetch_rsp_valid),
        .ifetch_rsp_ready (ifetch_rsp_ready),
        .ifetch_rsp       (ifetch_rsp),
        .data_req_valid   (data_req_valid),
        .data_req_ready   (data_req_ready),
        .data_req         (data_req),
        .data_rsp_valid   (data_rsp_valid),
        .data_rsp_ready   (data_rsp_ready),
        .data_rsp         (data_rsp),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd              (cmd),
        .cmd_rsp_valid    (cmd_rsp_valid),
        .cmd_rsp_ready    (cmd_rsp_ready),
        .cmd_rsp          (cmd_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        #(watchdog_cycles * 40);
        $display("ERROR: watchdog expired after %0d cycles, responses still missing",
                 watchdog_cycles);
        $display("TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    function automatic bit coin(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    function automatic lookup_req_t rand_req();
        lookup_req_t r;
        int          k;
        k          = {$random(seed)} % 4;
        r.vpn2     = vpn2_pool[k];
        k          = {$random(seed)} % 3;
        r.asid     = asid_pool[k];
        r.odd_page = coin(50);
        return r;
    endfunction

    function automatic tlb_cmd_t rand_cmd(input int nth);
        tlb_cmd_t    c;
        lookup_req_t r;
        int          pick;
        r            = rand_req();
        c.entry.vpn2 = r.vpn2;
        c.entry.asid = r.asid;
        c.entry.g    = coin(25);
        c.entry.lo0  = tlb_lo_t'($random(seed));
        c.entry.lo1  = tlb_lo_t'($random(seed));
        c.index      = tlb_index_t'({$random(seed)} % n_entries);
        pick         = {$random(seed)} % 10;
        if (nth < 8) begin
            c.op = op_probe;   // empty tlb first
        end else if (pick < 4) begin
            c.op = op_write_index;
        end else if (pick < 7) begin
            c.op = op_write_random;
        end else begin
            c.op = op_probe;
        end
        return c;
    endfunction

    // lowest present entry with equal vpn2 and a global bit or equal asid
    function automatic lookup_rsp_t model_lookup(input lookup_req_t r);
        lookup_rsp_t res;
        res = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (!res.found && ref_present[i] && ref_entries[i].vpn2 == r.vpn2
                    && (ref_entries[i].g || ref_entries[i].asid == r.asid)) begin
                res.found = 1'b1;
                res.index = tlb_index_t'(i);
                res.lo    = r.odd_page ? ref_entries[i].lo1 : ref_entries[i].lo0;
            end
        end
        return res;
    endfunction

    function automatic bit all_done();
        return ifetch_issued == n_lookups && data_issued == n_lookups
            && cmd_issued == n_cmds && !ifetch_req_valid && !data_req_valid
            && !cmd_valid && exp_ifetch.size() == 0 && exp_data.size() == 0
            && exp_cmd.size() == 0;
    endfunction

    task automatic fail_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_lookup(input string what, input lookup_rsp_t exp,
                                input lookup_rsp_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t ns: %s expected found=%0b index=%0d lo=%h",
                     $time, what, exp.found, exp.index, exp.lo);
            $display("MISMATCH at %0t ns: %s got      found=%0b index=%0d lo=%h",
                     $time, what, act.found, act.index, act.lo);
            $display("TESTS FAILED");
            $fatal(1, "lookup response mismatch");
        end
    endtask

    task automatic check_cmd(input string what, input tlb_cmd_rsp_t exp,
                             input tlb_cmd_rsp_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t ns: %s expected op=%0d found=%0b index=%0d, got %0d %0b %0d",
                     $time, what, exp.op, exp.found, exp.index, act.op, act.found, act.index);
            $display("TESTS FAILED");
            $fatal(1, "command response mismatch");
        end
    endtask

    always @(posedge aclk) begin : edge_proc
        tlb_cmd_rsp_t r;
        lookup_req_t  pr;
        lookup_rsp_t  m;
        if (!reset) begin
            // a stalled response must not change
            if (ifetch_hold) check_lookup("ifetch held", ifetch_held, ifetch_rsp);
            if (data_hold) check_lookup("data held", data_held, data_rsp);
            if (cmd_hold) check_cmd("cmd held", cmd_held, cmd_rsp);
            if (ifetch_rsp_valid && !ifetch_rsp_ready && ifetch_req_ready)
                fail_run("ifetch request ready is high while its response is stalled");
            if (data_rsp_valid && !data_rsp_ready && data_req_ready)
                fail_run("data request ready is high while its response is stalled");
            if (cmd_rsp_valid && !cmd_rsp_ready && cmd_ready)
                fail_run("command ready is high while its response is stalled");

            if (ifetch_rsp_valid && ifetch_rsp_ready) begin
                if (exp_ifetch.size() == 0)
                    fail_run("ifetch response arrived with no request outstanding");
                else
                    check_lookup("ifetch", exp_ifetch.pop_front(), ifetch_rsp);
            end
            if (data_rsp_valid && data_rsp_ready) begin
                if (exp_data.size() == 0)
                    fail_run("data response arrived with no request outstanding");
                else
                    check_lookup("data", exp_data.pop_front(), data_rsp);
            end
            if (cmd_rsp_valid && cmd_rsp_ready) begin
                if (exp_cmd.size() == 0)
                    fail_run("command response arrived with no command outstanding");
                else
                    check_cmd("cmd", exp_cmd.pop_front(), cmd_rsp);
            end
            ifetch_hold = ifetch_rsp_valid && !ifetch_rsp_ready;
            ifetch_held = ifetch_rsp;
            data_hold   = data_rsp_valid && !data_rsp_ready;
            data_held   = data_rsp;
            cmd_hold    = cmd_rsp_valid && !cmd_rsp_ready;
            cmd_held    = cmd_rsp;

            // lookups first since they see the array before this edge's write
            if (ifetch_req_valid && ifetch_req_ready) begin
                exp_ifetch.push_back(model_lookup(ifetch_req));
            end
            if (data_req_valid && data_req_ready) begin
                exp_data.push_back(model_lookup(data_req));
            end
            if (cmd_valid && cmd_ready) begin
                r    = '0;
                r.op = cmd.op;
                if (cmd.op == op_probe) begin
                    pr      = '0;
                    pr.vpn2 = cmd.entry.vpn2;
                    pr.asid = cmd.entry.asid;
                    m       = model_lookup(pr);
                    r.found = m.found;
                    r.index = m.index;
                end else begin
                    r.index = (cmd.op == op_write_random) ? ref_random : cmd.index;
                    ref_entries[r.index] = cmd.entry;
                    ref_present[r.index] = 1'b1;
                    if (cmd.op == op_write_random) begin
                        ref_random = (ref_random == 0) ? tlb_index_t'(n_entries - 1)
                                                       : ref_random - 1'b1;
                    end
                end
                exp_cmd.push_back(r);
            end

            // next requests are held until accepted
            if (!ifetch_req_valid || ifetch_req_ready) begin
                if (ifetch_issued < n_lookups && coin(60)) begin
                    ifetch_req_valid <= 1'b1;
                    ifetch_req       <= rand_req();
                    ifetch_issued++;
                end else begin
                    ifetch_req_valid <= 1'b0;
                end
            end
            if (!data_req_valid || data_req_ready) begin
                if (data_issued < n_lookups && coin(60)) begin
                    data_req_valid <= 1'b1;
                    data_req       <= rand_req();
                    data_issued++;
                end else begin
                    data_req_valid <= 1'b0;
                end
            end
            if (!cmd_valid || cmd_ready) begin
                if (cmd_issued < n_cmds && coin(60)) begin
                    cmd_valid <= 1'b1;
                    cmd       <= rand_cmd(cmd_issued);
                    cmd_issued++;
                end else begin
                    cmd_valid <= 1'b0;
                end
            end
            ifetch_rsp_ready <= coin(75);
            data_rsp_ready   <= coin(75);
            cmd_rsp_ready    <= coin(75);
        end
    end

    initial begin
        repeat (reset_cycles) @(posedge aclk);
        reset <= 1'b0;
        @(negedge aclk);
        while (!all_done()) @(negedge aclk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
hw/tlb_pkg.sv
hw/tlb_entry_array.sv
hw/tlb_match.sv
hw/tlb_lookup_port.sv
hw/tlb_cmd_unit.sv
hw/tlb_top.sv
dv/tlb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tlb_tb -o tlb_sim

out=$(./obj_dir/tlb_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
